//--- flist.f
verilog/zclk_pkg.sv
verilog/zphase_gen.sv
verilog/io_wait_gen.sv
verilog/zclock.sv
verilog/zclk_top.sv
verif/zclk_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the Z80 clock generator testbench with Verilator and runs it.
# The run counts as failed when the log holds the testbench's fail line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module zclk_tb \
	-f flist.f

./obj_dir/Vzclk_tb > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
	echo "simulation reported failures"
	exit 1
fi

echo "simulation passed"
exit 0

//--- verif/zclk_tb.sv
// Testbench for the Z80 clock generator top level.
// Concurrent assertions watch strobes, clock level, mode latch and I/O waits
// on every fclk edge; the test sequence only steers the DUT into those cases.
// Inputs change 1 ns after the rising fclk edge.
// The expected I/O wait is rebuilt from the zpos at which an access starts.

`timescale 1ns/1ns

module zclk_tb;

	import zclk_pkg::*;

	logic               fclk;
	logic               rst_n;
	logic               rfsh_n;
	logic [TURBO_W-1:0] turbo;
	logic               zclk_stall;
	logic               external_port;
	logic               iorq_n;
	logic               m1_n;
	logic               zclk_out;
	logic               zpos;
	logic               zneg;
	logic [TURBO_W-1:0] int_turbo;

	int errors;
	int tests_done;
	int errors_at_start;
	int seed;

	// reference state, all sampled on the rising fclk edge
	logic               last_pos;
	logic               zclk_q;
	logic               rfsh_at_zpos;
	logic [TURBO_W-1:0] turbo_q;
	logic [TURBO_W-1:0] prev_turbo;
	logic [3:0]         mode_age;
	logic [7:0]         gap;
	logic [1:0]         zpos_seen;
	logic               io_seen;
	logic [3:0]         wstep;
	logic               exp_wait;

	logic               io_now;
	logic               fast_now;
	logic               load_now;
	logic               disturbed;
	logic [7:0]         exp_period;

	zclk_top dut (
		.fclk         (fclk),
		.rst_n        (rst_n),
		.rfsh_n       (rfsh_n),
		.turbo        (turbo),
		.zclk_stall   (zclk_stall),
		.external_port(external_port),
		.iorq_n       (iorq_n),
		.m1_n         (m1_n),
		.zclk_out     (zclk_out),
		.zpos         (zpos),
		.zneg         (zneg),
		.int_turbo    (int_turbo)
	);

	initial fclk = 1'b0;
	always #2 fclk = ~fclk;

	// upper turbo bit alone selects 14 MHz
	function automatic logic fast_mode(input logic [TURBO_W-1:0] t);
		return t[TURBO_W-1];
	endfunction

	// zpos spacing in fclk cycles for a mode
	function automatic logic [7:0] strobe_period(input logic [TURBO_W-1:0] t);
		if (fast_mode(t))
			return 8'd2;
		else if (t == TURBO_70)
			return 8'd4;
		else
			return 8'd8;
	endfunction

	// wait step k of 0..7: high 5, low 1, high 1, low 1
	function automatic logic in_wait_pattern(input logic [3:0] k);
		return (k < 4'd5) || (k == 4'd6);
	endfunction

	assign io_now     = !iorq_n && m1_n && external_port;
	assign fast_now   = fast_mode(int_turbo);
	assign load_now   = zpos && rfsh_at_zpos && !rfsh_n;
	assign disturbed  = zclk_stall || exp_wait || (int_turbo != prev_turbo);
	assign exp_period = strobe_period(int_turbo);

	always @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			last_pos     <= 1'b1;
			zclk_q       <= 1'b0;
			rfsh_at_zpos <= 1'b1;
			turbo_q      <= TURBO_35;
			prev_turbo   <= TURBO_35;
			mode_age     <= 4'd0;
			gap          <= 8'd0;
			zpos_seen    <= 2'd0;
		end
		else
		begin
			zclk_q     <= zclk_out;
			turbo_q    <= turbo;
			prev_turbo <= int_turbo;
			// clock level as left by the latest strobe
			if (zpos)
			begin
				last_pos     <= 1'b1;
				rfsh_at_zpos <= rfsh_n;
			end
			else if (zneg)
				last_pos <= 1'b0;
			if (int_turbo != prev_turbo)
				mode_age <= 4'd0;
			else if (mode_age != 4'hf)
				mode_age <= mode_age + 4'd1;
			if (zpos)
				gap <= 8'd1;
			else if (gap != 8'hff)
				gap <= gap + 8'd1;
			// spacing is only judged between two zpos with nothing in between
			if (disturbed)
				zpos_seen <= 2'd0;
			else if (zpos && zpos_seen != 2'd3)
				zpos_seen <= zpos_seen + 2'd1;
		end
	end

	// expected io wait, one step per fclk after the starting zpos
	always @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			io_seen  <= 1'b0;
			wstep    <= 4'd0;
			exp_wait <= 1'b0;
		end
		else
		begin
			exp_wait <= (wstep != 4'd0) && in_wait_pattern(wstep - 4'd1);
			if (zpos)
				io_seen <= io_now;
			if (zpos && io_now && !io_seen && fast_now)
				wstep <= 4'd1;
			else if (wstep == 4'd8)
				wstep <= 4'd0;
			else if (wstep != 4'd0)
				wstep <= wstep + 4'd1;
		end
	end

	no_overlap: assert property (@(posedge fclk) disable iff (!rst_n) !(zpos && zneg))
		else report_mismatch("zpos_zneg", 8'h0, 8'({$sampled(zpos), $sampled(zneg)}));
	pos_after_neg: assert property (@(posedge fclk) disable iff (!rst_n) zpos |-> !last_pos)
		else report_mismatch("zpos", 8'h0, 8'($sampled(zpos)));
	neg_after_pos: assert property (@(posedge fclk) disable iff (!rst_n) zneg |-> last_pos)
		else report_mismatch("zneg", 8'h0, 8'($sampled(zneg)));
	low_after_pos: assert property (@(posedge fclk) disable iff (!rst_n) zpos |-> !zclk_out)
		else report_mismatch("zclk_out", 8'h0, 8'($sampled(zclk_out)));
	high_after_neg: assert property (@(posedge fclk) disable iff (!rst_n) zneg |-> zclk_out)
		else report_mismatch("zclk_out", 8'h1, 8'($sampled(zclk_out)));
	level_holds: assert property (@(posedge fclk) disable iff (!rst_n)
		!zpos && !zneg |-> zclk_out == zclk_q)
		else report_mismatch("zclk_out", 8'($sampled(zclk_q)), 8'($sampled(zclk_out)));
	stall_blocks: assert property (@(posedge fclk) disable iff (!rst_n)
		zclk_stall |=> !zpos && !zneg)
		else report_mismatch("zpos_zneg", 8'h0, 8'({$sampled(zpos), $sampled(zneg)}));
	io_wait_blocks: assert property (@(posedge fclk) disable iff (!rst_n)
		exp_wait |=> !zpos && !zneg)
		else report_mismatch("zpos_zneg", 8'h0, 8'({$sampled(zpos), $sampled(zneg)}));
	// settled 14 MHz issues a strobe after every unstalled edge
	fast_resumes: assert property (@(posedge fclk) disable iff (!rst_n)
		fast_now && mode_age >= 4'd4 && !zclk_stall && !exp_wait |=> zpos || zneg)
		else report_mismatch("zpos_zneg", $sampled(last_pos) ? 8'h1 : 8'h2,
			8'({$sampled(zpos), $sampled(zneg)}));
	zpos_spacing: assert property (@(posedge fclk) disable iff (!rst_n)
		zpos && zpos_seen != 2'd0 |-> gap == exp_period)
		else report_mismatch("zpos period", $sampled(exp_period), $sampled(gap));
	mode_loads: assert property (@(posedge fclk) disable iff (!rst_n)
		load_now |=> int_turbo == turbo_q)
		else report_mismatch("int_turbo", 8'($sampled(turbo_q)), 8'($sampled(int_turbo)));
	mode_holds: assert property (@(posedge fclk) disable iff (!rst_n)
		!load_now |=> int_turbo == prev_turbo)
		else report_mismatch("int_turbo", 8'($sampled(prev_turbo)), 8'($sampled(int_turbo)));

	task automatic report_mismatch(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		errors++;
		$display("CHECK FAILED %s: expected 0x%0h got 0x%0h at %0t ns",
			name, expected, actual, $time);
	endtask

	task automatic print_counts();
		$display("tests finished: %0d, errors: %0d", tests_done, errors);
	endtask

	task automatic give_up(input string what);
		$display("Timeout: no %s seen within the cycle limit at %0t ns", what, $time);
		errors++;
		print_counts();
		$display("Errors found");
		$finish;
	endtask

	task automatic finish_test(input string name);
		tests_done++;
		$display("test %0d %s: %s, %0d errors", tests_done, name,
			(errors == errors_at_start) ? "ok" : "failed", errors - errors_at_start);
		errors_at_start = errors;
	endtask

	task automatic tick(input int n);
		repeat (n)
		begin
			@(posedge fclk);
			#1;
		end
	endtask

	// returns in a cycle where zpos is high
	task automatic await_zpos(input int limit);
		int n;
		n = 0;
		tick(1);
		while (!zpos && n < limit)
		begin
			tick(1);
			n++;
		end
		if (!zpos)
			give_up("zpos");
	endtask

	// rfsh_n falls together with a zpos, then rises again for the next load
	task automatic load_mode(input logic [TURBO_W-1:0] t);
		turbo = t;
		await_zpos(40);
		rfsh_n = 1'b0;
		tick(6);
		assert (int_turbo == t)
			else report_mismatch("int_turbo", 8'(t), 8'(int_turbo));
		rfsh_n = 1'b1;
		tick(24);
	endtask

	// external io access starting at a zpos
	task automatic io_access(input int len);
		await_zpos(40);
		iorq_n = 1'b0;
		m1_n = 1'b1;
		external_port = 1'b1;
		tick(len);
		iorq_n = 1'b1;
		external_port = 1'b0;
		tick(16);
	endtask

	initial
	begin
		logic [TURBO_W-1:0] modes [3];
		logic [31:0] r;
		modes = '{TURBO_35, TURBO_70, TURBO_140};
		seed = 65;
		errors = 0;
		tests_done = 0;
		errors_at_start = 0;
		rst_n = 1'b0;
		rfsh_n = 1'b1;
		turbo = TURBO_35;
		zclk_stall = 1'b0;
		external_port = 1'b0;
		iorq_n = 1'b1;
		m1_n = 1'b1;
		repeat (4) @(posedge fclk);
		#1;
		assert (!zpos && !zneg && !zclk_out)
			else report_mismatch("zpos_zneg_zclk_out", 8'h0, 8'({zpos, zneg, zclk_out}));
		assert (int_turbo == TURBO_35)
			else report_mismatch("int_turbo", 8'(TURBO_35), 8'(int_turbo));
		rst_n = 1'b1;
		tick(64);
		finish_test("reset_and_3p5mhz");

		// request alone must not change the mode
		turbo = TURBO_70;
		tick(40);
		assert (int_turbo == TURBO_35)
			else report_mismatch("int_turbo", 8'(TURBO_35), 8'(int_turbo));
		load_mode(TURBO_70);
		tick(40);
		load_mode(TURBO_140);
		tick(40);
		finish_test("mode_switch");

		repeat (8)
		begin
			r = $random(seed);
			load_mode(r[1:0]);
			tick(20 + int'(r[7:4]));
		end
		finish_test("strobe_alternation");

		for (int m = 0; m < 3; m++)
		begin
			load_mode(modes[m]);
			repeat (12)
			begin
				r = $random(seed);
				tick(1 + int'(r % 32'd5));
				zclk_stall = 1'b1;
				tick(1 + int'(r[15:8] % 8'd6));
				zclk_stall = 1'b0;
			end
			tick(30);
		end
		finish_test("stall");

		load_mode(TURBO_140);
		repeat (4) io_access(12);
		load_mode(TURBO_70);
		repeat (2) io_access(12);
		// only internal or M1 cycles at 14 MHz, never an external access
		load_mode(2'b11);
		repeat (80)
		begin
			r = $random(seed);
			iorq_n = r[0];
			m1_n = r[1];
			external_port = r[2];
			if (!r[0] && r[1] && r[2])
				m1_n = 1'b0;
			tick(1);
		end
		iorq_n = 1'b1;
		m1_n = 1'b1;
		external_port = 1'b0;
		tick(20);
		finish_test("io_wait");

		print_counts();
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- verilog/zclk_top.sv
// Top level of the Z80 clock generator.
// fclk must run at four times the 7 MHz rate.
// zclk_stall comes from the memory arbiter and may be held for any
// number of fclk cycles; the I/O wait is generated internally.
// zclk_out is meant to be inverted externally before the CPU.

`timescale 1ns/1ns

module zclk_top (
	input  logic                         fclk,
	input  logic                         rst_n,
	input  logic                         rfsh_n,
	input  logic [zclk_pkg::TURBO_W-1:0] turbo,
	input  logic                         zclk_stall,
	input  logic                         external_port,
	input  logic                         iorq_n,
	input  logic                         m1_n,
	output logic                         zclk_out,
	output logic                         zpos,
	output logic                         zneg,
	output logic [zclk_pkg::TURBO_W-1:0] int_turbo
);

	// sync strobes for the 7 and 3.5 MHz rates
	logic c0;
	logic c8;

	// io wait stall back into the clock generator
	logic io_wait;

	zphase_gen u_phase (
		.fclk (fclk),
		.rst_n(rst_n),
		.c0   (c0),
		.c8   (c8)
	);

	io_wait_gen u_io_wait (
		.fclk         (fclk),
		.rst_n        (rst_n),
		.zpos         (zpos),
		.int_turbo    (int_turbo),
		.external_port(external_port),
		.iorq_n       (iorq_n),
		.m1_n         (m1_n),
		.io_wait      (io_wait)
	);

	zclock u_zclock (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.rfsh_n    (rfsh_n),
		.turbo     (turbo),
		.zclk_stall(zclk_stall),
		.io_wait   (io_wait),
		.c0        (c0),
		.c8        (c8),
		.int_turbo (int_turbo),
		.zpos      (zpos),
		.zneg      (zneg),
		.zclk_out  (zclk_out)
	);

endmodule

//--- verilog/zclock.sv
// Z80 clock generator: 14, 7 or 3.5 MHz from fclk (28 MHz).
// zclk_out is inverted on the board, so zpos announces the coming
// rising edge of the CPU clock and zneg the falling one.
// The requested mode is taken over only when rfsh_n falls, sampled at zpos.
// A stall blocks both strobes; at 14 MHz the internal toggle freezes too,
// while at 7 and 3.5 MHz strobes falling inside a stall are lost.
// zclk_out is updated on the falling fclk edge after a strobe.

`timescale 1ns/1ns

module zclock (
	input  logic                         fclk,
	input  logic                         rst_n,
	input  logic                         rfsh_n,
	input  logic [zclk_pkg::TURBO_W-1:0] turbo,
	input  logic                         zclk_stall,
	input  logic                         io_wait,
	input  logic                         c0,
	input  logic                         c8,
	output logic [zclk_pkg::TURBO_W-1:0] int_turbo,
	output logic                         zpos,
	output logic                         zneg,
	output logic                         zclk_out
);

	import zclk_pkg::*;

	// rfsh_n as sampled at the previous zpos
	logic old_rfsh_n;

	// combined stall from arbiter and io waits
	logic stall;

	// 14 MHz source, toggles every unstalled fclk
	logic clk14_src;

	// selects every other c8 for 3.5 MHz
	logic prec3_cnt;

	logic fast;
	logic pre_zpos_35;
	logic pre_zneg_35;
	logic pre_zpos_70;
	logic pre_zneg_70;
	logic pre_zpos_140;
	logic pre_zneg_140;
	logic pre_zpos;
	logic pre_zneg;

	// mode switch, only in the refresh part of M1
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			old_rfsh_n <= 1'b1;
			int_turbo  <= TURBO_35;
		end
		else if (zpos)
		begin
			old_rfsh_n <= rfsh_n;
			if (old_rfsh_n && !rfsh_n)
				int_turbo <= turbo;
		end
	end

	assign stall = zclk_stall | io_wait;

	// 14 MHz: toggle holds during stall so the clock resumes in phase
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			clk14_src <= 1'b0;
		else if (!stall)
			clk14_src <= ~clk14_src;
	end

	assign pre_zpos_140 = clk14_src;
	assign pre_zneg_140 = ~clk14_src;

	// 7 MHz straight from the sync strobes
	assign pre_zpos_70 = c8;
	assign pre_zneg_70 = c0;

	// 3.5 MHz: c8 halved, alternate pulses rise and fall
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			prec3_cnt <= 1'b0;
		else if (c8)
			prec3_cnt <= ~prec3_cnt;
	end

	assign pre_zpos_35 = ~prec3_cnt & c8;
	assign pre_zneg_35 = prec3_cnt & c8;

	// any code with the upper bit set runs at 14 MHz
	assign fast = |(int_turbo & TURBO_140);

	always_comb
	begin
		if (fast)
		begin
			pre_zpos = pre_zpos_140;
			pre_zneg = pre_zneg_140;
		end
		else if (int_turbo == TURBO_70)
		begin
			pre_zpos = pre_zpos_70;
			pre_zneg = pre_zneg_70;
		end
		else
		begin
			pre_zpos = pre_zpos_35;
			pre_zneg = pre_zneg_35;
		end
	end

	// strobes gated by the present clock level, so they always alternate
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			zpos <= 1'b0;
			zneg <= 1'b0;
		end
		else
		begin
			zpos <= ~stall & pre_zpos & zclk_out;
			zneg <= ~stall & pre_zneg & ~zclk_out;
		end
	end

	// half an fclk lead on the CPU clock edges
	// output inverted on the board, so low here is CPU clock high
	always_ff @(negedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			zclk_out <= 1'b0;
		else if (zpos)
			zclk_out <= 1'b0;
		else if (zneg)
			zclk_out <= 1'b1;
	end

endmodule

//--- verilog/io_wait_gen.sv
// Wait-state generator for external I/O accesses in 14 MHz mode.
// The I/O condition is sampled only at zpos, so a new access is seen
// on the first CPU rising edge where it holds.
// Nothing is started at 3.5 or 7 MHz; a sequence already running
// finishes even if the mode changes meanwhile.
// io_wait is registered and trails the counter by one fclk cycle.

`timescale 1ns/1ns

module io_wait_gen (
	input  logic                         fclk,
	input  logic                         rst_n,
	input  logic                         zpos,
	input  logic [zclk_pkg::TURBO_W-1:0] int_turbo,
	input  logic                         external_port,
	input  logic                         iorq_n,
	input  logic                         m1_n,
	output logic                         io_wait
);

	import zclk_pkg::*;

	// external io cycle, not an interrupt acknowledge
	logic io;
	// io as seen at the previous zpos
	logic io_r;
	// running at 14 MHz
	logic fast;
	// wait counter and its running flag
	logic [IOW_CNT_W-1:0] io_wait_cnt;
	logic run;

	assign io   = ~iorq_n & m1_n & external_port;
	assign fast = |(int_turbo & TURBO_140);
	assign run  = io_wait_cnt[IOW_CNT_W-1];

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			io_r <= 1'b0;
		else if (zpos)
			io_r <= io;
	end

	// start with only the top bit set, then count until it wraps to zero
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			io_wait_cnt <= '0;
		else if (io && !io_r && zpos && fast)
			io_wait_cnt <= {1'b1, {(IOW_CNT_W-1){1'b0}}};
		else if (run)
			io_wait_cnt <= io_wait_cnt + IOW_CNT_W'(1);
	end

	// pattern lookup by the low counter bits
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			io_wait <= 1'b0;
		else
			io_wait <= run & IOW_PATTERN[io_wait_cnt[IOW_CNT_W-2:0]];
	end

endmodule

//--- verilog/zphase_gen.sv
// Free-running fclk phase counter standing in for the arbiter cycle counter.
// c0 and c8 are registered one-fclk pulses, each once per 4 fclk cycles,
// with c8 two cycles behind c0.
// The phase is not aligned to anything outside; only the relative
// spacing of the two strobes matters to the clock generator.

`timescale 1ns/1ns

module zphase_gen (
	input  logic fclk,
	input  logic rst_n,
	output logic c0,
	output logic c8
);

	// position inside the 4-cycle 7 MHz period
	logic [1:0] phase;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase <= 2'd0;
		end
		else
		begin
			phase <= phase + 2'd1;
		end
	end

	// strobes are registered, so decode one state ahead
	// c0 is high while phase reads 0, c8 while it reads 2
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			c0 <= 1'b0;
			c8 <= 1'b0;
		end
		else
		begin
			c0 <= (phase == 2'd3);
			c8 <= (phase == 2'd1);
		end
	end

endmodule

//--- verilog/zclk_pkg.sv
// Shared constants for the Z80 clock generator.
// Turbo codes 2'b00 and 2'b01 select 3.5 and 7 MHz; any code with the
// upper bit set selects 14 MHz, so decode that bit through TURBO_140.
// The I/O wait counter is idle while its top bit is clear and walks
// through IOW_LEN states once started.

package zclk_pkg;

	// turbo mode field
	localparam int TURBO_W = 2;

	// 3.5 MHz, fclk/8
	localparam logic [TURBO_W-1:0] TURBO_35 = 2'b00;
	// 7 MHz, fclk/4
	localparam logic [TURBO_W-1:0] TURBO_70 = 2'b01;
	// 14 MHz, fclk/2; also used as the mask of the 14 MHz bit
	localparam logic [TURBO_W-1:0] TURBO_140 = 2'b10;

	// io wait counter, top bit means sequence running
	localparam int IOW_CNT_W = 4;

	// number of counter states in one wait sequence
	localparam int IOW_LEN = 1 << (IOW_CNT_W - 1);

	// stall pattern indexed by the low counter bits
	// states 0..4 stall, 5 free, 6 stall, 7 free
	localparam logic [IOW_LEN-1:0] IOW_PATTERN = 8'b0101_1111;

endpackage
